/* sparse_feed_top.f */
verilog/sparse_feed_pkg.sv
verilog/pipe_stage.sv
verilog/flag_row_reader.sv
verilog/nonzero_index_scan.sv
verilog/serial_data_fetch.sv
verilog/kernel_window_reader.sv
verilog/sparse_feed_top.sv
testbench/tb_sparse_feed.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_sparse_feed
FILELIST  = sparse_feed_top.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'Test OK'

clean:
	rm -rf $(OBJ_DIR)

/* testbench/tb_sparse_feed.sv */
`timescale 1ns/1ps

module tb_sparse_feed;

  localparam int CLK_PERIOD    = 10;
  localparam int MAX_ITEMS     = 16 * 16;             // all rows full
  localparam int COLLECT_LIMIT = 4 * MAX_ITEMS + 100;  // random ready near 50 percent
  localparam int TEST_CYCLES   = 300 + COLLECT_LIMIT;  // memory fill plus stream
  localparam int NUM_TESTS     = 5;

  logic clk = 1'b0;
  logic reset;
  sparse_feed_pkg::flag_write_t                flag_wr_i;
  logic                                        flag_wr_valid_i;
  sparse_feed_pkg::data_write_t                data_wr_i;
  logic                                        data_wr_valid_i;
  sparse_feed_pkg::kernel_write_t              kernel_wr_i;
  logic                                        kernel_wr_valid_i;
  logic                                        start_i;
  logic [sparse_feed_pkg::COUNT_W-1:0]         row_count_i;
  logic [sparse_feed_pkg::BLOCK_ADDR_W-1:0]    kernel_block_i;
  logic                                        busy_o;
  sparse_feed_pkg::kernel_window_t             kernel_window_o;
  logic                                        kernel_valid_o;
  sparse_feed_pkg::stream_item_t               stream_o;
  logic                                        stream_valid_o;
  logic                                        stream_ready_i;

  sparse_feed_pkg::flag_row_t    flag_model [16];   // host view of the memories
  sparse_feed_pkg::data_t        data_model [256];
  sparse_feed_pkg::stream_item_t exp_q [$];
  logic [31:0]                   lfsr_state = 32'h2b2a_39dd;
  int                            errors = 0;
  int                            tests_run = 0;
  int                            tests_failed = 0;

  sparse_feed_top #(.SDATA_DEPTH(256), .KERNEL_BLOCKS(28)) dut_i (
    .clk(clk), .reset(reset),
    .flag_wr_i(flag_wr_i), .flag_wr_valid_i(flag_wr_valid_i),
    .data_wr_i(data_wr_i), .data_wr_valid_i(data_wr_valid_i),
    .kernel_wr_i(kernel_wr_i), .kernel_wr_valid_i(kernel_wr_valid_i),
    .start_i(start_i), .row_count_i(row_count_i), .kernel_block_i(kernel_block_i),
    .busy_o(busy_o), .kernel_window_o(kernel_window_o), .kernel_valid_o(kernel_valid_o),
    .stream_o(stream_o), .stream_valid_o(stream_valid_o), .stream_ready_i(stream_ready_i)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1
    end
    return s >> 1;
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic sparse_feed_pkg::data_t rand_byte();
    logic [31:0] v;
    v = rand_bits(8);
    return v[7:0];
  endfunction

  // reference stream for rows 0 to rc-1, bytes counted from address 0
  function automatic void build_expected(int rc);
    int ptr;
    int cnt;
    int top_col;
    sparse_feed_pkg::stream_item_t it;
    exp_q.delete();
    ptr = 0;
    for (int r = 0; r < rc; r++) begin
      cnt = 0;
      top_col = -1;
      for (int c = 0; c < 16; c++) begin
        if (flag_model[r][c]) begin
          cnt++;
          top_col = c;
        end
      end
      if (cnt == 0) begin
        it = '0;
        it.idx.row   = r[3:0];
        it.idx.empty = 1'b1;   // no byte consumed
        it.idx.last  = (r == rc - 1);
        exp_q.push_back(it);
      end
      for (int c = 0; c < 16; c++) begin
        if (flag_model[r][c]) begin
          it = '0;
          it.idx.row   = r[3:0];
          it.idx.col   = c[3:0];
          it.idx.count = cnt[4:0];
          it.idx.last  = (r == rc - 1) && (c == top_col);
          it.data      = data_model[ptr % 256];
          ptr++;
          exp_q.push_back(it);
        end
      end
    end
  endfunction

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_window(string name, sparse_feed_pkg::kernel_window_t got,
                              sparse_feed_pkg::kernel_window_t exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_item(string name, sparse_feed_pkg::stream_item_t got,
                            sparse_feed_pkg::stream_item_t exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // host writes, called and returning 1 ns after a rising edge
  task automatic write_flag(logic [3:0] row, sparse_feed_pkg::flag_row_t mask);
    flag_wr_i.addr  = row;
    flag_wr_i.mask  = mask;
    flag_wr_valid_i = 1'b1;
    flag_model[row] = mask;
    @(posedge clk);
    #1;
    flag_wr_valid_i = 1'b0;
  endtask

  task automatic write_data(logic [7:0] addr, sparse_feed_pkg::data_t value);
    data_wr_i.addr  = addr;
    data_wr_i.data  = value;
    data_wr_valid_i = 1'b1;
    data_model[addr] = value;
    @(posedge clk);
    #1;
    data_wr_valid_i = 1'b0;
  endtask

  task automatic fill_data_pattern(int n, sparse_feed_pkg::data_t salt);
    for (int i = 0; i < n; i++) begin
      write_data(i[7:0], i[7:0] ^ salt);
    end
  endtask

  task automatic write_kernel(logic [4:0] block, sparse_feed_pkg::kernel_window_t lanes,
                              logic [8:0] keep);
    kernel_wr_i.addr  = block;
    kernel_wr_i.lanes = lanes;
    kernel_wr_i.keep  = keep;
    kernel_wr_valid_i = 1'b1;
    @(posedge clk);
    #1;
    kernel_wr_valid_i = 1'b0;
  endtask

  task automatic start_job(logic [4:0] rc, logic [4:0] block);
    start_i        = 1'b1;
    row_count_i    = rc;
    kernel_block_i = block;
    @(posedge clk);  // accepting edge when idle
    #1;
    start_i = 1'b0;
  endtask

  // drain the stream against exp_q, sampling at the falling edge
  task automatic collect_stream(logic random_ready);
    int n;
    int cycles;
    logic done;
    logic [31:0] r;
    n = 0;
    cycles = 0;
    done = 1'b0;
    while (!done && cycles < COLLECT_LIMIT) begin
      r = random_ready ? rand_bits(1) : 32'd1;
      stream_ready_i = r[0];
      @(negedge clk);
      if (stream_valid_o && stream_ready_i) begin
        if (n < exp_q.size()) begin
          check_item($sformatf("stream_o[%0d]", n), stream_o, exp_q[n]);
        end else begin
          errors++;
          $display("stream_o delivered an extra item at %0t", $time);
        end
        n++;
        done = stream_o.idx.last;
      end
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!done) begin
      errors++;
      $display("stream never marked its last item within %0d cycles", COLLECT_LIMIT);
    end
    if (n != exp_q.size()) begin
      errors++;
      $display("stream gave %0d items where %0d were expected", n, exp_q.size());
    end
  endtask

  task automatic report_test(string name, int errs0);
    tests_run++;
    if (errors > errs0) begin
      tests_failed++;
      $display("test %s failed with %0d errors", name, errors - errs0);
    end else begin
      $display("test %s passed", name);
    end
  endtask

  task automatic test_kernel_masking();
    int errs0;
    logic [4:0] blocks [4];
    logic [8:0] keeps [4];
    sparse_feed_pkg::kernel_window_t lanes;
    sparse_feed_pkg::kernel_window_t expw [4];
    errs0  = errors;
    blocks = '{5'd0, 5'd5, 5'd13, 5'd27};
    keeps  = '{9'h1ff, 9'h0a5, 9'h13c, 9'h000};
    write_flag(4'd0, 16'h0011);
    fill_data_pattern(2, 8'h3c);
    for (int b = 0; b < 4; b++) begin
      for (int l = 0; l < 9; l++) begin
        lanes[l]   = rand_byte();
        expw[b][l] = keeps[b][l] ? lanes[l] : 8'h00;  // cleared flag reads zero
      end
      write_kernel(blocks[b], lanes, keeps[b]);
    end
    for (int b = 0; b < 4; b++) begin
      stream_ready_i = 1'b0;  // stream waits while the window is checked
      start_job(5'd1, blocks[b]);
      for (int k = 1; k <= 4; k++) begin
        @(negedge clk);
        check_bit("kernel_valid_o", kernel_valid_o, k == 2);
        if (k >= 2) begin
          check_window("kernel_window_o", kernel_window_o, expw[b]);
        end
      end
      @(posedge clk);
      #1;
      build_expected(1);
      collect_stream(1'b0);
    end
    report_test("kernel_masking", errs0);
  endtask

  task automatic test_basic_stream();
    int errs0;
    errs0 = errors;
    write_flag(4'd0, 16'h0091);
    write_flag(4'd1, 16'h8002);
    write_flag(4'd2, 16'h0410);
    fill_data_pattern(16, 8'ha7);
    build_expected(3);
    stream_ready_i = 1'b1;
    start_job(5'd3, 5'd0);
    collect_stream(1'b0);
    report_test("basic_stream", errs0);
  endtask

  task automatic test_edge_rows();
    int errs0;
    sparse_feed_pkg::flag_row_t masks [16];
    errs0 = errors;
    masks = '{16'h0000, 16'hffff, 16'h0001, 16'h8000, 16'h0000, 16'h0300, 16'h0041, 16'h1000,
              16'h0808, 16'h0000, 16'h4002, 16'h0020, 16'h0e00, 16'h0004, 16'h8001, 16'h0000};
    for (int r = 0; r < 16; r++) begin
      write_flag(r[3:0], masks[r]);
    end
    fill_data_pattern(64, 8'h19);
    build_expected(16);
    start_job(5'd16, 5'd1);
    collect_stream(1'b0);
    report_test("edge_rows", errs0);
  endtask

  task automatic test_back_pressure();
    int errs0;
    logic [31:0] m;
    errs0 = errors;
    for (int r = 0; r < 16; r++) begin
      m = rand_bits(16);
      write_flag(r[3:0], m[15:0]);
    end
    for (int i = 0; i < 256; i++) begin
      write_data(i[7:0], rand_byte());
    end
    build_expected(16);
    start_job(5'd16, 5'd2);
    collect_stream(1'b1);
    report_test("back_pressure", errs0);
  endtask

  task automatic test_busy_behavior();
    int errs0;
    errs0 = errors;
    write_flag(4'd0, 16'h0201);
    write_flag(4'd1, 16'h0000);
    write_flag(4'd2, 16'h1c00);
    fill_data_pattern(8, 8'h5a);
    build_expected(3);
    stream_ready_i = 1'b0;
    start_job(5'd3, 5'd0);
    check_bit("busy_o", busy_o, 1'b1);
    repeat (3) @(posedge clk);
    #1;
    start_i     = 1'b1;  // must be ignored while busy
    row_count_i = 5'd1;
    @(posedge clk);
    #1;
    start_i = 1'b0;
    check_bit("busy_o", busy_o, 1'b1);
    collect_stream(1'b0);
    check_bit("busy_o", busy_o, 1'b0);
    fill_data_pattern(8, 8'hc3);  // new bytes, read again from address 0
    build_expected(3);
    start_job(5'd3, 5'd0);
    collect_stream(1'b0);
    check_bit("busy_o", busy_o, 1'b0);
    report_test("busy_behavior", errs0);
  endtask

  initial begin
    #(NUM_TESTS * TEST_CYCLES * 2 * CLK_PERIOD);
    $display("watchdog expired, the run did not finish in time");
    $display("Test FAILED");
    $finish;
  end

  initial begin
    reset             = 1'b0;
    flag_wr_i         = '0;
    flag_wr_valid_i   = 1'b0;
    data_wr_i         = '0;
    data_wr_valid_i   = 1'b0;
    kernel_wr_i       = '0;
    kernel_wr_valid_i = 1'b0;
    start_i           = 1'b0;
    row_count_i       = 5'd1;
    kernel_block_i    = '0;
    stream_ready_i    = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b1;
    check_bit("busy_o", busy_o, 1'b0);
    check_bit("kernel_valid_o", kernel_valid_o, 1'b0);
    check_bit("stream_valid_o", stream_valid_o, 1'b0);
    test_kernel_masking();
    test_basic_stream();
    test_edge_rows();
    test_back_pressure();
    test_busy_behavior();
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* verilog/sparse_feed_top.sv */
`timescale 1ns/1ps

module sparse_feed_top #(
  parameter int SDATA_DEPTH   = 256,
  parameter int KERNEL_BLOCKS = 28
) (
  input  logic                                     clk,
  input  logic                                     reset,
  input  sparse_feed_pkg::flag_write_t             flag_wr_i,
  input  logic                                     flag_wr_valid_i,
  input  sparse_feed_pkg::data_write_t             data_wr_i,
  input  logic                                     data_wr_valid_i,
  input  sparse_feed_pkg::kernel_write_t           kernel_wr_i,
  input  logic                                     kernel_wr_valid_i,
  input  logic                                     start_i,
  input  logic [sparse_feed_pkg::COUNT_W-1:0]      row_count_i,
  input  logic [sparse_feed_pkg::BLOCK_ADDR_W-1:0] kernel_block_i,
  output logic                                     busy_o,
  output sparse_feed_pkg::kernel_window_t          kernel_window_o,
  output logic                                     kernel_valid_o,
  output sparse_feed_pkg::stream_item_t            stream_o,
  output logic                                     stream_valid_o,
  input  logic                                     stream_ready_i
);

  logic launch;

  sparse_feed_pkg::row_item_t    row_raw, row_s;
  logic                          row_raw_valid, row_raw_ready, row_s_valid, row_s_ready;
  sparse_feed_pkg::index_item_t  idx_raw, idx_s;
  logic                          idx_raw_valid, idx_raw_ready, idx_s_valid, idx_s_ready;
  sparse_feed_pkg::stream_item_t item_raw;
  logic                          item_raw_valid, item_raw_ready;

  assign launch = start_i && !busy_o;  // start ignored while busy

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      busy_o <= 1'b0;
    end else if (launch) begin
      busy_o <= 1'b1;
    end else if (stream_valid_o && stream_ready_i && stream_o.idx.last) begin
      busy_o <= 1'b0;
    end
  end

  kernel_window_reader #(.KERNEL_BLOCKS(KERNEL_BLOCKS)) u_kernel (
    .clk(clk), .reset(reset),
    .kernel_wr_i(kernel_wr_i), .kernel_wr_valid_i(kernel_wr_valid_i),
    .launch_i(launch), .block_i(kernel_block_i),
    .window_o(kernel_window_o), .window_valid_o(kernel_valid_o)
  );

  flag_row_reader u_rows (
    .clk(clk), .reset(reset),
    .flag_wr_i(flag_wr_i), .flag_wr_valid_i(flag_wr_valid_i),
    .launch_i(launch), .row_count_i(row_count_i),
    .row_o(row_raw), .row_valid_o(row_raw_valid), .row_ready_i(row_raw_ready)
  );

  pipe_stage #(.payload_t(sparse_feed_pkg::row_item_t)) u_row_slice (
    .clk(clk), .reset(reset),
    .in_i(row_raw), .in_valid_i(row_raw_valid), .in_ready_o(row_raw_ready),
    .out_o(row_s), .out_valid_o(row_s_valid), .out_ready_i(row_s_ready)
  );

  nonzero_index_scan u_scan (
    .clk(clk), .reset(reset),
    .row_i(row_s), .row_valid_i(row_s_valid), .row_ready_o(row_s_ready),
    .idx_o(idx_raw), .idx_valid_o(idx_raw_valid), .idx_ready_i(idx_raw_ready)
  );

  pipe_stage #(.payload_t(sparse_feed_pkg::index_item_t)) u_idx_slice (
    .clk(clk), .reset(reset),
    .in_i(idx_raw), .in_valid_i(idx_raw_valid), .in_ready_o(idx_raw_ready),
    .out_o(idx_s), .out_valid_o(idx_s_valid), .out_ready_i(idx_s_ready)
  );

  serial_data_fetch #(.SDATA_DEPTH(SDATA_DEPTH)) u_fetch (
    .clk(clk), .reset(reset),
    .data_wr_i(data_wr_i), .data_wr_valid_i(data_wr_valid_i),
    .launch_i(launch),
    .idx_i(idx_s), .idx_valid_i(idx_s_valid), .idx_ready_o(idx_s_ready),
    .item_o(item_raw), .item_valid_o(item_raw_valid), .item_ready_i(item_raw_ready)
  );

  // output slice, stream_ready_i only reaches a register
  pipe_stage #(.payload_t(sparse_feed_pkg::stream_item_t)) u_out_slice (
    .clk(clk), .reset(reset),
    .in_i(item_raw), .in_valid_i(item_raw_valid), .in_ready_o(item_raw_ready),
    .out_o(stream_o), .out_valid_o(stream_valid_o), .out_ready_i(stream_ready_i)
  );

endmodule

/* verilog/kernel_window_reader.sv */
`timescale 1ns/1ps

module kernel_window_reader #(
  parameter int KERNEL_BLOCKS = 28
) (
  input  logic                                     clk,
  input  logic                                     reset,
  input  sparse_feed_pkg::kernel_write_t           kernel_wr_i,
  input  logic                                     kernel_wr_valid_i,
  input  logic                                     launch_i,
  input  logic [sparse_feed_pkg::BLOCK_ADDR_W-1:0] block_i,
  output sparse_feed_pkg::kernel_window_t          window_o,
  output logic                                     window_valid_o
);

  sparse_feed_pkg::kernel_window_t               lane_mem [KERNEL_BLOCKS];
  logic [sparse_feed_pkg::KERNEL_LANES-1:0]      keep_mem [KERNEL_BLOCKS];

  sparse_feed_pkg::kernel_window_t          lanes_q;
  logic [sparse_feed_pkg::KERNEL_LANES-1:0] keep_q;
  logic                                     rd_valid;
  sparse_feed_pkg::kernel_window_t          masked;

  always_ff @(posedge clk) begin
    if (kernel_wr_valid_i) begin
      lane_mem[kernel_wr_i.addr] <= kernel_wr_i.lanes;
      keep_mem[kernel_wr_i.addr] <= kernel_wr_i.keep;
    end
  end

  // stage 1, block read
  always_ff @(posedge clk) begin
    if (launch_i) begin
      lanes_q <= lane_mem[block_i];
      keep_q  <= keep_mem[block_i];
    end
  end

  // lanes with a cleared keep flag read as zero
  always_comb begin
    masked = '0;
    for (int l = 0; l < sparse_feed_pkg::KERNEL_LANES; l++) begin
      if (keep_q[l]) begin
        masked[l] = lanes_q[l];
      end
    end
  end

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      rd_valid       <= 1'b0;
      window_valid_o <= 1'b0;
    end else begin
      rd_valid       <= launch_i;
      window_valid_o <= rd_valid;  // single pulse per launch
    end
  end

  // stage 2, window held until the next launch
  always_ff @(posedge clk) begin
    if (rd_valid) begin
      window_o <= masked;
    end
  end

  a_block_range : assert property (@(posedge clk) disable iff (!reset)
    launch_i |-> block_i < KERNEL_BLOCKS);

endmodule

/* verilog/serial_data_fetch.sv */
`timescale 1ns/1ps

module serial_data_fetch #(
  parameter int SDATA_DEPTH = 256
) (
  input  logic                          clk,
  input  logic                          reset,
  input  sparse_feed_pkg::data_write_t  data_wr_i,
  input  logic                          data_wr_valid_i,
  input  logic                          launch_i,
  input  sparse_feed_pkg::index_item_t  idx_i,
  input  logic                          idx_valid_i,
  output logic                          idx_ready_o,
  output sparse_feed_pkg::stream_item_t item_o,
  output logic                          item_valid_o,
  input  logic                          item_ready_i
);

  sparse_feed_pkg::data_t data_mem [SDATA_DEPTH];

  logic [sparse_feed_pkg::SDATA_ADDR_W-1:0] rd_ptr;
  logic                                     take;

  always_ff @(posedge clk) begin
    if (data_wr_valid_i) begin
      data_mem[data_wr_i.addr] <= data_wr_i.data;
    end
  end

  // output slot holds under stall, new item only when it drains
  assign idx_ready_o = !item_valid_o || item_ready_i;
  assign take        = idx_valid_i && idx_ready_o;

  // read pointer, one step per consumed byte
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      rd_ptr <= '0;
    end else if (launch_i) begin
      rd_ptr <= '0;
    end else if (take && !idx_i.empty) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      item_valid_o <= 1'b0;
    end else if (take) begin
      item_valid_o <= 1'b1;
    end else if (item_ready_i) begin
      item_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      item_o.idx  <= idx_i;
      item_o.data <= idx_i.empty ? '0 : data_mem[rd_ptr];  // empty rows carry no byte
    end
  end

  // launch only comes once the previous stream has fully drained
  a_launch_idle : assert property (@(posedge clk) disable iff (!reset)
    launch_i |-> !item_valid_o && !idx_valid_i);

endmodule

/* verilog/nonzero_index_scan.sv */
`timescale 1ns/1ps

module nonzero_index_scan (
  input  logic                         clk,
  input  logic                         reset,
  input  sparse_feed_pkg::row_item_t   row_i,
  input  logic                         row_valid_i,
  output logic                         row_ready_o,
  output sparse_feed_pkg::index_item_t idx_o,
  output logic                         idx_valid_o,
  input  logic                         idx_ready_i
);

  logic                                   have_row;
  sparse_feed_pkg::flag_row_t             work_q;   // bits still to emit
  sparse_feed_pkg::flag_row_t             mask_q;   // row mask as received
  sparse_feed_pkg::flag_row_t             rest;
  logic [sparse_feed_pkg::ROW_ADDR_W-1:0] row_q;
  logic [sparse_feed_pkg::COUNT_W-1:0]    count_q;
  logic                                   last_row_q;
  logic [sparse_feed_pkg::COL_W-1:0]      col;
  logic                                   take_row;
  logic                                   take_idx;

  assign rest = work_q & (work_q - 1'b1);  // drop lowest set bit

  // lowest set bit wins, zero mask gives column 0
  always_comb begin
    col = '0;
    for (int i = sparse_feed_pkg::ROW_W - 1; i >= 0; i--) begin
      if (work_q[i]) begin
        col = i[sparse_feed_pkg::COL_W-1:0];
      end
    end
  end

  assign idx_valid_o = have_row;
  assign idx_o.row   = row_q;
  assign idx_o.col   = col;
  assign idx_o.count = count_q;
  assign idx_o.empty = (mask_q == '0);
  assign idx_o.last  = last_row_q && (rest == '0);

  assign take_idx    = idx_valid_o && idx_ready_i;
  // next row loads in the same cycle the final index leaves
  assign row_ready_o = !have_row || (take_idx && (rest == '0));
  assign take_row    = row_valid_i && row_ready_o;

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      have_row <= 1'b0;
    end else if (take_row) begin
      have_row <= 1'b1;
    end else if (take_idx && (rest == '0)) begin
      have_row <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take_row) begin
      work_q     <= row_i.mask;
      mask_q     <= row_i.mask;
      row_q      <= row_i.row;
      count_q    <= row_i.count;
      last_row_q <= row_i.last;
    end else if (take_idx) begin
      work_q <= rest;
    end
  end

  // every emitted column must come from the row that was handed in
  a_col_in_mask : assert property (@(posedge clk) disable iff (!reset)
    idx_valid_o && !idx_o.empty |-> mask_q[idx_o.col]);

endmodule

/* verilog/flag_row_reader.sv */
`timescale 1ns/1ps

module flag_row_reader (
  input  logic                                clk,
  input  logic                                reset,
  input  sparse_feed_pkg::flag_write_t        flag_wr_i,
  input  logic                                flag_wr_valid_i,
  input  logic                                launch_i,
  input  logic [sparse_feed_pkg::COUNT_W-1:0] row_count_i,
  output sparse_feed_pkg::row_item_t          row_o,
  output logic                                row_valid_o,
  input  logic                                row_ready_i
);

  localparam int ROWS = 2 ** sparse_feed_pkg::ROW_ADDR_W;

  sparse_feed_pkg::flag_row_t flag_mem [ROWS];

  logic                                   active;
  logic                                   advance;
  logic [sparse_feed_pkg::ROW_ADDR_W-1:0] rd_row;
  logic [sparse_feed_pkg::ROW_ADDR_W-1:0] last_row;
  logic [sparse_feed_pkg::COUNT_W-1:0]    count_m1;
  logic [sparse_feed_pkg::ROW_ADDR_W-1:0] row_q;
  sparse_feed_pkg::flag_row_t             mask_q;
  logic                                   last_q;
  logic [sparse_feed_pkg::COUNT_W-1:0]    pop;

  always_ff @(posedge clk) begin
    if (flag_wr_valid_i) begin
      flag_mem[flag_wr_i.addr] <= flag_wr_i.mask;
    end
  end

  assign count_m1 = row_count_i - 1'b1;
  assign advance  = active && (!row_valid_o || row_ready_i);  // pause while stalled

  // row walker
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      active   <= 1'b0;
      rd_row   <= '0;
      last_row <= '0;
    end else if (launch_i) begin
      active   <= 1'b1;
      rd_row   <= '0;
      last_row <= count_m1[sparse_feed_pkg::ROW_ADDR_W-1:0];
    end else if (advance) begin
      rd_row <= rd_row + 1'b1;
      if (rd_row == last_row) begin
        active <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      row_valid_o <= 1'b0;
    end else if (advance) begin
      row_valid_o <= 1'b1;
    end else if (row_ready_i) begin
      row_valid_o <= 1'b0;
    end
  end

  // registered memory read doubles as the output register
  always_ff @(posedge clk) begin
    if (advance) begin
      mask_q <= flag_mem[rd_row];
      row_q  <= rd_row;
      last_q <= (rd_row == last_row);
    end
  end

  always_comb begin
    pop = '0;
    for (int i = 0; i < sparse_feed_pkg::ROW_W; i++) begin
      pop = pop + mask_q[i];
    end
  end

  assign row_o.row   = row_q;
  assign row_o.mask  = mask_q;
  assign row_o.count = pop;
  assign row_o.last  = last_q;

endmodule

/* verilog/pipe_stage.sv */
`timescale 1ns/1ps

module pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  payload_t in_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  output payload_t out_o,
  output logic     out_valid_o,
  input  logic     out_ready_i
);

  payload_t main_q;
  payload_t skid_q;
  logic     main_valid;
  logic     skid_valid;
  logic     push;
  logic     pop;

  assign in_ready_o  = !skid_valid;  // registered ready, no path from out_ready_i
  assign out_o       = main_q;
  assign out_valid_o = main_valid;

  assign push = in_valid_i && !skid_valid;
  assign pop  = main_valid && out_ready_i;

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (pop) begin
      if (skid_valid) begin
        skid_valid <= 1'b0;  // main refills from skid
      end else begin
        main_valid <= push;
      end
    end else if (push) begin
      if (main_valid) begin
        skid_valid <= 1'b1;  // output stalled, park it
      end else begin
        main_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop && skid_valid) begin
      main_q <= skid_q;
    end else if (push && (pop || !main_valid)) begin
      main_q <= in_i;
    end
    if (push && main_valid && !pop) begin
      skid_q <= in_i;
    end
  end

  // a stalled item must not change under the consumer
  a_out_stable : assert property (@(posedge clk) disable iff (!reset)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_o));

endmodule

/* verilog/sparse_feed_pkg.sv */
package sparse_feed_pkg;

  localparam int DATA_W       = 8;
  localparam int ROW_W        = 16;
  localparam int ROW_ADDR_W   = 4;
  localparam int COL_W        = 4;
  localparam int COUNT_W      = 5;   // 0 to 16 nonzeros
  localparam int KERNEL_LANES = 9;
  localparam int BLOCK_ADDR_W = 5;
  localparam int SDATA_ADDR_W = 8;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ROW_W-1:0]  flag_row_t;
  typedef data_t [KERNEL_LANES-1:0] kernel_window_t;  // lane 0 in the low byte

  // host write ports
  typedef struct packed {
    logic [ROW_ADDR_W-1:0] addr;
    flag_row_t             mask;
  } flag_write_t;

  typedef struct packed {
    logic [SDATA_ADDR_W-1:0] addr;
    data_t                   data;
  } data_write_t;

  typedef struct packed {
    logic [BLOCK_ADDR_W-1:0] addr;
    kernel_window_t          lanes;
    logic [KERNEL_LANES-1:0] keep;  // one keep flag per lane
  } kernel_write_t;

  // stream path items
  typedef struct packed {
    logic [ROW_ADDR_W-1:0] row;
    flag_row_t             mask;
    logic [COUNT_W-1:0]    count;
    logic                  last;    // final row of the walk
  } row_item_t;

  typedef struct packed {
    logic [ROW_ADDR_W-1:0] row;
    logic [COL_W-1:0]      col;
    logic [COUNT_W-1:0]    count;
    logic                  empty;   // row without set bits
    logic                  last;    // final item of the final row
  } index_item_t;

  typedef struct packed {
    index_item_t idx;
    data_t       data;
  } stream_item_t;

endpackage
